//--- hdl/ctrl_isa_pkg.sv
////////////////////////////////////////
// architectural types for the decode controller
// privilege levels, trap causes and interrupt requests
////////////////////////////////////////

package ctrl_isa_pkg;

  // maximum number of fast interrupt lines
  parameter int unsigned NUM_FAST_IRQ_MAX = 15;

  // privilege modes, only machine and user are implemented
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  ////////////////////////////////////////
  // trap causes
  ////////////////////////////////////////

  // top bit marks an interrupt, low five bits hold the code
  typedef enum logic [5:0] {
    EXC_CAUSE_INSN_ADDR_MISA     = {1'b0, 5'd0},
    EXC_CAUSE_INSTR_ACCESS_FAULT = {1'b0, 5'd1},
    EXC_CAUSE_ILLEGAL_INSN       = {1'b0, 5'd2},
    EXC_CAUSE_BREAKPOINT         = {1'b0, 5'd3},
    EXC_CAUSE_ECALL_UMODE        = {1'b0, 5'd8},
    EXC_CAUSE_ECALL_MMODE        = {1'b0, 5'd11},
    EXC_CAUSE_IRQ_SOFTWARE_M     = {1'b1, 5'd3},
    EXC_CAUSE_IRQ_TIMER_M        = {1'b1, 5'd7},
    EXC_CAUSE_IRQ_EXTERNAL_M     = {1'b1, 5'd11},
    EXC_CAUSE_IRQ_NM             = {1'b1, 5'd31}
  } exc_code_e;

  // same word split up, fast interrupt n reads as irq=1 fast=1 id=n
  typedef struct packed {
    logic       irq;
    logic       fast;
    logic [3:0] id;
  } exc_fields_t;

  // the cause is read as a plain code or built from its fields
  typedef union packed {
    exc_code_e   code;
    exc_fields_t fields;
  } exc_cause_u;

  // interrupt requests, already masked by the mie register
  typedef struct packed {
    logic                        irq_software;
    logic                        irq_timer;
    logic                        irq_external;
    logic [NUM_FAST_IRQ_MAX-1:0] irq_fast;
  } irqs_t;

endpackage

//--- hdl/ctrl_pipe_pkg.sv
////////////////////////////////////////
// pipeline side types between the controller
// and the fetch, decode and CSR blocks
////////////////////////////////////////

package ctrl_pipe_pkg;

  // fetch address select
  typedef enum logic [1:0] {
    PC_BOOT = 2'd0,
    PC_JUMP = 2'd1,
    PC_EXC  = 2'd2,
    PC_ERET = 2'd3
  } pc_sel_e;

  // which vector offset the fetch stage uses on PC_EXC
  typedef enum logic {
    EXC_PC_EXC = 1'b0,
    EXC_PC_IRQ = 1'b1
  } exc_pc_sel_e;

  // instruction held in the IF-ID register
  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
    // original 16 bit encoding, kept for mtval
    logic [15:0] rdata_c;
    logic        is_compressed;
    logic        fetch_err;
    // fault hit the upper half of an unaligned fetch
    logic        fetch_err_plus2;
    logic [31:0] pc;
  } instr_t;

  // raw decoder flags, not qualified with valid
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic wfi;
    logic ebrk;
    logic csr_pipe_flush;
    logic branch_set;
    logic jump_set;
  } dec_flags_t;

  // exception detector to FSM
  typedef struct packed {
    logic                    req;
    logic                    mret;
    logic                    wfi;
    ctrl_isa_pkg::exc_cause_u cause;
    logic [31:0]             mtval;
  } exc_info_t;

  // interrupt selector to FSM
  typedef struct packed {
    logic                    take;
    logic                    nmi;
    ctrl_isa_pkg::exc_cause_u cause;
  } irq_info_t;

  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_sel;
    exc_pc_sel_e exc_pc_sel;
  } pc_ctrl_t;

  typedef struct packed {
    logic                    save_if;
    logic                    save_id;
    logic                    save_cause;
    logic                    restore_mret;
    ctrl_isa_pkg::exc_cause_u cause;
    logic [31:0]             mtval;
  } csr_ctrl_t;

endpackage

//--- hdl/exc_detect.sv
////////////////////////////////////////
// synchronous exception detection for the
// instruction in ID, gives cause and mtval
////////////////////////////////////////

module exc_detect (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  ctrl_pipe_pkg::instr_t   instr_i,
  input  ctrl_pipe_pkg::dec_flags_t dec_i,
  input  ctrl_isa_pkg::priv_lvl_e priv_mode_i,
  input  logic                    trap_wfi_i,
  // controller is in FLUSH, drop requests already handled
  input  logic                    in_flush_i,
  output ctrl_pipe_pkg::exc_info_t exc_o
);
  import ctrl_isa_pkg::*;

  logic       illegal_insn;
  logic       ecall_insn;
  logic       mret_insn;
  logic       wfi_insn;
  logic       ebrk_insn;
  logic       fetch_err;
  logic       illegal_umode;
  logic       illegal_d;
  logic       illegal_q;
  logic       exc_req_d;
  logic       exc_req_q;
  exc_cause_u cause;
  logic [31:0] mtval;

  // decoder flags ignore valid, so qualify them here
  assign illegal_insn = dec_i.illegal & instr_i.valid;
  assign ecall_insn   = dec_i.ecall & instr_i.valid;
  assign mret_insn    = dec_i.mret & instr_i.valid;
  assign wfi_insn     = dec_i.wfi & instr_i.valid;
  assign ebrk_insn    = dec_i.ebrk & instr_i.valid;
  assign fetch_err    = instr_i.fetch_err & instr_i.valid;

  // mret is M-mode only, wfi traps in U-mode when mstatus.tw is set
  assign illegal_umode = (priv_mode_i != PRIV_LVL_M) &
                         (mret_insn | (trap_wfi_i & wfi_insn));

  // both flops clear in FLUSH so a handled request does not come back
  assign illegal_d = (illegal_insn | illegal_umode) & ~in_flush_i;
  assign exc_req_d = (ecall_insn | ebrk_insn | illegal_d | fetch_err) & ~in_flush_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q <= 1'b0;
      exc_req_q <= 1'b0;
    end else begin
      illegal_q <= illegal_d;
      exc_req_q <= exc_req_d;
    end
  end

  ////////////////////////////////////////
  // prioritisation
  ////////////////////////////////////////

  // fetch fault, then illegal, then ecall, then ebreak
  always_comb begin
    cause.code = EXC_CAUSE_INSN_ADDR_MISA;
    mtval      = '0;
    if (fetch_err) begin
      cause.code = EXC_CAUSE_INSTR_ACCESS_FAULT;
      // upper half fault reports the address of the second half
      mtval      = instr_i.fetch_err_plus2 ? instr_i.pc + 32'd2 : instr_i.pc;
    end else if (illegal_q) begin
      cause.code = EXC_CAUSE_ILLEGAL_INSN;
      mtval      = instr_i.is_compressed ? {16'b0, instr_i.rdata_c} : instr_i.rdata;
    end else if (ecall_insn) begin
      cause.code = (priv_mode_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE :
                                                 EXC_CAUSE_ECALL_UMODE;
    end else if (ebrk_insn) begin
      cause.code = EXC_CAUSE_BREAKPOINT;
    end
  end

  // in DECODE the live request counts, in FLUSH the registered one
  always_comb begin
    exc_o.req   = exc_req_d | exc_req_q;
    exc_o.mret  = mret_insn;
    exc_o.wfi   = wfi_insn;
    exc_o.cause = cause;
    exc_o.mtval = mtval;
  end

endmodule

//--- hdl/irq_select.sv
////////////////////////////////////////
// interrupt arbitration and NMI mode flag
////////////////////////////////////////

module irq_select #(
  parameter int unsigned NumFastIrq = 15
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  ctrl_isa_pkg::irqs_t      irqs_i,
  input  logic                     irq_nm_i,
  // mstatus.mie
  input  logic                     irq_en_i,
  // strobes from the FSM
  input  logic                     irq_taken_i,
  input  logic                     mret_done_i,
  output ctrl_pipe_pkg::irq_info_t irq_o,
  output logic                     nmi_mode_o
);
  import ctrl_isa_pkg::*;

  // only the low NumFastIrq fast lines are wired up
  localparam logic [NUM_FAST_IRQ_MAX-1:0] FastMask =
      {NUM_FAST_IRQ_MAX{1'b1}} >> (NUM_FAST_IRQ_MAX - NumFastIrq);

  logic [NUM_FAST_IRQ_MAX-1:0] fast_req;
  logic [3:0]                  fast_id;
  logic                        irq_pending;
  logic                        nmi_mode_q;
  exc_cause_u                  cause;

  assign fast_req    = irqs_i.irq_fast & FastMask;
  assign irq_pending = (|fast_req) | irqs_i.irq_external |
                       irqs_i.irq_software | irqs_i.irq_timer;

  // highest numbered fast line wins, later iterations override
  always_comb begin
    fast_id = '0;
    for (int i = 0; i < NUM_FAST_IRQ_MAX; i++) begin
      if (fast_req[i]) begin
        fast_id = 4'(i);
      end
    end
  end

  // cause.fields.irq also doubles as "something pending" for wake-up
  always_comb begin
    cause = '0;
    if (irq_nm_i) begin
      cause.code = EXC_CAUSE_IRQ_NM;
    end else if (|fast_req) begin
      // fast n encodes as 16 + n
      cause.fields.irq  = 1'b1;
      cause.fields.fast = 1'b1;
      cause.fields.id   = fast_id;
    end else if (irqs_i.irq_external) begin
      cause.code = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irqs_i.irq_software) begin
      cause.code = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else if (irqs_i.irq_timer) begin
      cause.code = EXC_CAUSE_IRQ_TIMER_M;
    end
  end

  // no nesting inside the NMI handler, NMI ignores mie
  always_comb begin
    irq_o.take  = ~nmi_mode_q & (irq_nm_i | (irq_pending & irq_en_i));
    irq_o.nmi   = irq_nm_i;
    irq_o.cause = cause;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nmi_mode_q <= 1'b0;
    end else if (irq_taken_i && irq_nm_i) begin
      nmi_mode_q <= 1'b1;
    end else if (mret_done_i) begin
      nmi_mode_q <= 1'b0;
    end
  end

  assign nmi_mode_o = nmi_mode_q;

endmodule

//--- hdl/ctrl_fsm.sv
////////////////////////////////////////
// decode stage controller FSM, drives the PC mux,
// CSR save/restore strobes and ID stall/flush
////////////////////////////////////////

module ctrl_fsm (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  ctrl_pipe_pkg::instr_t      instr_i,
  input  ctrl_pipe_pkg::dec_flags_t  dec_i,
  input  ctrl_pipe_pkg::exc_info_t   exc_i,
  input  ctrl_pipe_pkg::irq_info_t   irq_i,
  input  logic                       stall_id_i,
  // to the exception and interrupt blocks
  output logic                       in_flush_o,
  output logic                       irq_taken_o,
  output logic                       mret_done_o,
  // to fetch and the IF-ID register
  output ctrl_pipe_pkg::pc_ctrl_t    pc_ctrl_o,
  output logic                       instr_req_o,
  output logic                       id_in_ready_o,
  output logic                       instr_valid_clear_o,
  output logic                       flush_id_o,
  // to the CSR file
  output ctrl_pipe_pkg::csr_ctrl_t   csr_ctrl_o,
  output logic                       ctrl_busy_o
);
  import ctrl_pipe_pkg::*;

  typedef enum logic [2:0] {
    RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN
  } ctrl_fsm_e;

  ctrl_fsm_e state_q;
  ctrl_fsm_e state_d;

  logic csr_pipe_flush;
  logic special_req;
  logic special_req_branch;
  logic halt_if;
  logic retain_id;
  logic flush_id;

  assign csr_pipe_flush = dec_i.csr_pipe_flush & instr_i.valid;

  // anything that needs a trip through FLUSH
  assign special_req = exc_i.req | exc_i.mret | exc_i.wfi | csr_pipe_flush;

  // a faulting fetch never redirects on a branch
  assign special_req_branch = instr_i.fetch_err & instr_i.valid;

  always_comb begin
    state_d     = state_q;
    instr_req_o = 1'b1;
    ctrl_busy_o = 1'b1;
    halt_if     = 1'b0;
    retain_id   = 1'b0;
    flush_id    = 1'b0;
    irq_taken_o = 1'b0;
    mret_done_o = 1'b0;
    // mux selects only matter when pc_set is high
    pc_ctrl_o.pc_set     = 1'b0;
    pc_ctrl_o.pc_sel     = PC_BOOT;
    pc_ctrl_o.exc_pc_sel = EXC_PC_IRQ;
    csr_ctrl_o           = '0;

    unique case (state_q)
      RESET: begin
        instr_req_o      = 1'b0;
        pc_ctrl_o.pc_set = 1'b1;
        state_d          = BOOT_SET;
      end

      BOOT_SET: begin
        // boot address into fetch, requests start now
        pc_ctrl_o.pc_set = 1'b1;
        state_d          = FIRST_FETCH;
      end

      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        state_d     = SLEEP;
      end

      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        // wake on any pending line, enabled or not
        if (irq_i.nmi || irq_i.cause.fields.irq) begin
          state_d = FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end

      FIRST_FETCH: begin
        // wait for the first instruction to land in ID
        if (!stall_id_i) begin
          state_d = DECODE;
        end
        if (irq_i.take) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end

      DECODE: begin
        pc_ctrl_o.pc_sel = PC_JUMP;

        // hold the instruction so FLUSH can still see it
        if (special_req) begin
          retain_id = 1'b1;
          if (!stall_id_i) begin
            state_d = FLUSH;
          end
        end

        if (!special_req_branch && (dec_i.branch_set || dec_i.jump_set)) begin
          pc_ctrl_o.pc_set = 1'b1;
        end

        // interrupt waits for the current instruction to finish
        if (irq_i.take) begin
          halt_if = 1'b1;
          if (!stall_id_i && !special_req) begin
            state_d = IRQ_TAKEN;
          end
        end
      end

      IRQ_TAKEN: begin
        pc_ctrl_o.pc_sel     = PC_EXC;
        pc_ctrl_o.exc_pc_sel = EXC_PC_IRQ;
        // request may have dropped meanwhile, then just resume
        if (irq_i.take) begin
          pc_ctrl_o.pc_set      = 1'b1;
          csr_ctrl_o.save_if    = 1'b1;
          csr_ctrl_o.save_cause = 1'b1;
          csr_ctrl_o.cause      = irq_i.cause;
          irq_taken_o           = 1'b1;
        end
        state_d = DECODE;
      end

      FLUSH: begin
        halt_if = 1'b1;
        flush_id = 1'b1;
        state_d = DECODE;

        if (exc_i.req) begin
          // trap, epc comes from the instruction in ID
          pc_ctrl_o.pc_set      = 1'b1;
          pc_ctrl_o.pc_sel      = PC_EXC;
          pc_ctrl_o.exc_pc_sel  = EXC_PC_EXC;
          csr_ctrl_o.save_id    = 1'b1;
          csr_ctrl_o.save_cause = 1'b1;
          csr_ctrl_o.cause      = exc_i.cause;
          csr_ctrl_o.mtval      = exc_i.mtval;
        end else if (exc_i.mret) begin
          pc_ctrl_o.pc_set        = 1'b1;
          pc_ctrl_o.pc_sel        = PC_ERET;
          csr_ctrl_o.restore_mret = 1'b1;
          // also leaves NMI mode
          mret_done_o             = 1'b1;
        end else if (exc_i.wfi) begin
          state_d = WAIT_SLEEP;
        end else if (csr_pipe_flush && irq_i.take) begin
          // CSR write may have just unmasked an interrupt
          state_d = IRQ_TAKEN;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////
  // stall and flush
  ////////////////////////////////////////

  assign in_flush_o    = (state_q == FLUSH);
  assign flush_id_o    = flush_id;
  assign id_in_ready_o = ~stall_id_i & ~halt_if & ~retain_id;

  // retain keeps valid set unless flush overrides it
  assign instr_valid_clear_o = ~(stall_id_i | retain_id) | flush_id;

endmodule

//--- hdl/ctrl_top.sv
////////////////////////////////////////
// decode controller top, connects exception,
// interrupt and FSM blocks to the pipeline
////////////////////////////////////////

module ctrl_top #(
  parameter int unsigned NumFastIrq = 15
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // IF-ID register and decoder
  input  ctrl_pipe_pkg::instr_t     instr_i,
  input  ctrl_pipe_pkg::dec_flags_t dec_i,
  // interrupt sources
  input  ctrl_isa_pkg::irqs_t       irqs_i,
  input  logic                      irq_nm_i,
  // CSR state
  input  logic                      irq_en_i,
  input  ctrl_isa_pkg::priv_lvl_e   priv_mode_i,
  input  logic                      trap_wfi_i,
  input  logic                      stall_id_i,
  // fetch side
  output ctrl_pipe_pkg::pc_ctrl_t   pc_ctrl_o,
  output logic                      instr_req_o,
  output logic                      id_in_ready_o,
  output logic                      instr_valid_clear_o,
  output logic                      flush_id_o,
  // CSR side
  output ctrl_pipe_pkg::csr_ctrl_t  csr_ctrl_o,
  output logic                      nmi_mode_o,
  output logic                      ctrl_busy_o
);
  import ctrl_pipe_pkg::*;

  exc_info_t exc_info;
  irq_info_t irq_info;
  logic      in_flush;
  logic      irq_taken;
  logic      mret_done;

  exc_detect exc_detect_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .instr_i     (instr_i),
    .dec_i       (dec_i),
    .priv_mode_i (priv_mode_i),
    .trap_wfi_i  (trap_wfi_i),
    .in_flush_i  (in_flush),
    .exc_o       (exc_info)
  );

  irq_select #(
    .NumFastIrq (NumFastIrq)
  ) irq_select_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .irqs_i      (irqs_i),
    .irq_nm_i    (irq_nm_i),
    .irq_en_i    (irq_en_i),
    .irq_taken_i (irq_taken),
    .mret_done_i (mret_done),
    .irq_o       (irq_info),
    .nmi_mode_o  (nmi_mode_o)
  );

  ctrl_fsm ctrl_fsm_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_i             (instr_i),
    .dec_i               (dec_i),
    .exc_i               (exc_info),
    .irq_i               (irq_info),
    .stall_id_i          (stall_id_i),
    .in_flush_o          (in_flush),
    .irq_taken_o         (irq_taken),
    .mret_done_o         (mret_done),
    .pc_ctrl_o           (pc_ctrl_o),
    .instr_req_o         (instr_req_o),
    .id_in_ready_o       (id_in_ready_o),
    .instr_valid_clear_o (instr_valid_clear_o),
    .flush_id_o          (flush_id_o),
    .csr_ctrl_o          (csr_ctrl_o),
    .ctrl_busy_o         (ctrl_busy_o)
  );

endmodule

//--- bench/ctrl_tests.svh
////////////////////////////////////////
// directed test tasks included into the testbench top
// each task starts and ends at a falling clock edge
////////////////////////////////////////

// one instruction through DECODE and FLUSH that ends in a trap
task automatic run_exc(input instr_t ins, input dec_flags_t d, input priv_lvl_e priv,
                       input logic tw, input logic [5:0] exp_cause,
                       input logic [31:0] exp_mtval);
  instr     = ins;
  dec       = d;
  priv_mode = priv;
  trap_wfi  = tw;
  settle();
  // held in ID until the flush
  check_eq("id ready on trap", 0, id_in_ready);
  step();
  settle();
  check_redirect(PC_EXC);
  check_eq("exception vector", EXC_PC_EXC, pc_ctrl.exc_pc_sel);
  check_eq("csr strobes", 4'b0110, strobes);
  check_eq("cause", exp_cause, csr_ctrl.cause.code);
  check_eq("mtval", exp_mtval, csr_ctrl.mtval);
  check_eq("flush id", 1, flush_id);
  step();
  clear_instr();
endtask

task automatic run_mret();
  instr.valid = 1'b1;
  instr.rdata = 32'h3020_0073;
  dec.mret    = 1'b1;
  settle();
  check_eq("id ready on mret", 0, id_in_ready);
  step();
  settle();
  check_redirect(PC_ERET);
  check_eq("csr strobes on mret", 4'b0001, strobes);
  step();
  clear_instr();
endtask

// already driven request is seen in DECODE and taken one cycle later
task automatic take_irq(input logic [5:0] exp_cause);
  settle();
  check_eq("fetch halted for irq", 0, id_in_ready);
  step();
  settle();
  check_redirect(PC_EXC);
  check_eq("irq vector", EXC_PC_IRQ, pc_ctrl.exc_pc_sel);
  check_eq("csr strobes on irq", 4'b1010, strobes);
  check_eq("irq cause", exp_cause, csr_ctrl.cause.code);
  step();
endtask

task automatic boot_sequence();
  test_name = "boot";
  settle();
  check_redirect(PC_BOOT);
  check_eq("instr_req in reset", 0, instr_req);
  step();
  settle();
  check_redirect(PC_BOOT);
  check_eq("instr_req in boot", 1, instr_req);
  step();
  settle();
  check_eq("pc set first fetch", 0, pc_ctrl.pc_set);
  check_eq("instr_req first fetch", 1, instr_req);
  check_eq("csr strobes first fetch", 0, strobes);
  check_eq("flush id first fetch", 0, flush_id);
  check_eq("id ready first fetch", 1, id_in_ready);
  step();
endtask

task automatic illegal_and_fault();
  instr_t      ins;
  dec_flags_t  d;
  logic [31:0] word;
  test_name = "illegal and fault";
  word      = $random(seed);
  ins       = '0;
  ins.valid = 1'b1;
  ins.rdata = word;
  ins.pc    = 32'h0000_1000;
  d         = '0;
  d.illegal = 1'b1;
  run_exc(ins, d, PRIV_LVL_M, 1'b0, cause_of(1'b0, 2), word);
  // only the 16 bit parcel of a compressed word lands in mtval
  ins.is_compressed = 1'b1;
  ins.rdata_c       = 16'($random(seed));
  run_exc(ins, d, PRIV_LVL_M, 1'b0, cause_of(1'b0, 2), {16'h0, ins.rdata_c});
  // fault on the upper half wins over illegal
  ins.is_compressed   = 1'b0;
  ins.fetch_err       = 1'b1;
  ins.fetch_err_plus2 = 1'b1;
  ins.pc              = $random(seed);
  ins.pc[0]           = 1'b0;
  run_exc(ins, d, PRIV_LVL_M, 1'b0, cause_of(1'b0, 1), ins.pc + 32'd2);
endtask

task automatic ecall_ebreak_mret();
  instr_t     ins;
  dec_flags_t d;
  test_name = "ecall ebreak mret";
  ins       = '0;
  ins.valid = 1'b1;
  ins.rdata = $random(seed);
  ins.pc    = 32'h0000_2000;
  d         = '0;
  d.ecall   = 1'b1;
  run_exc(ins, d, PRIV_LVL_M, 1'b0, cause_of(1'b0, 11), 32'h0);
  run_exc(ins, d, PRIV_LVL_U, 1'b0, cause_of(1'b0, 8), 32'h0);
  d      = '0;
  d.ebrk = 1'b1;
  run_exc(ins, d, PRIV_LVL_M, 1'b0, cause_of(1'b0, 3), 32'h0);
  run_mret();
  // mret and trapped wfi are illegal outside M-mode
  d      = '0;
  d.mret = 1'b1;
  run_exc(ins, d, PRIV_LVL_U, 1'b0, cause_of(1'b0, 2), ins.rdata);
  d     = '0;
  d.wfi = 1'b1;
  run_exc(ins, d, PRIV_LVL_U, 1'b1, cause_of(1'b0, 2), ins.rdata);
endtask

task automatic irq_priority();
  test_name         = "irq priority";
  irqs.irq_software = 1'b1;
  irqs.irq_timer    = 1'b1;
  irqs.irq_external = 1'b1;
  // fast lines 9 and 3
  irqs.irq_fast     = 15'h0208;
  // with mie clear nothing but an NMI may be taken
  repeat (3) begin
    settle();
    check_eq("strobes while disabled", 0, strobes);
    check_eq("pc set while disabled", 0, pc_ctrl.pc_set);
    step();
  end
  irq_nm = 1'b1;
  take_irq(cause_of(1'b1, 31));
  irq_nm = 1'b0;
  irq_en = 1'b1;
  // nothing nests inside the NMI handler
  repeat (3) begin
    settle();
    check_eq("nmi mode", 1, nmi_mode);
    check_eq("strobes in nmi mode", 0, strobes);
    step();
  end
  run_mret();
  settle();
  check_eq("nmi mode after mret", 0, nmi_mode);
  take_irq(cause_of(1'b1, 16 + 9));
  irqs.irq_fast = '0;
  take_irq(cause_of(1'b1, 11));
  irqs.irq_external = 1'b0;
  take_irq(cause_of(1'b1, 3));
  irqs.irq_software = 1'b0;
  take_irq(cause_of(1'b1, 7));
  irqs   = '0;
  irq_en = 1'b0;
endtask

task automatic sleep_wakeup();
  test_name   = "sleep";
  instr.valid = 1'b1;
  instr.rdata = 32'h1050_0073;
  dec.wfi     = 1'b1;
  settle();
  check_eq("id ready on wfi", 0, id_in_ready);
  step();
  settle();
  check_eq("pc set on wfi", 0, pc_ctrl.pc_set);
  check_eq("flush id on wfi", 1, flush_id);
  step();
  clear_instr();
  // WAIT_SLEEP followed by SLEEP with nothing pending
  repeat (3) begin
    settle();
    check_eq("busy while asleep", 0, ctrl_busy);
    check_eq("instr_req while asleep", 0, instr_req);
    step();
  end
  irqs.irq_timer = 1'b1;
  settle();
  check_eq("instr_req on wake", 0, instr_req);
  step();
  settle();
  check_eq("instr_req after wake", 1, instr_req);
  check_eq("busy after wake", 1, ctrl_busy);
  step();
  irqs.irq_timer = 1'b0;
  instr.valid    = 1'b1;
  dec.branch_set = 1'b1;
  settle();
  // only DECODE redirects on a branch
  check_redirect(PC_JUMP);
  check_eq("instr_req in decode", 1, instr_req);
  step();
  clear_instr();
endtask

task automatic branch_and_stall();
  test_name    = "branch and stall";
  instr.valid  = 1'b1;
  dec.jump_set = 1'b1;
  settle();
  check_redirect(PC_JUMP);
  check_eq("id ready on jump", 1, id_in_ready);
  step();
  clear_instr();
  stall_id          = 1'b1;
  irq_en            = 1'b1;
  irqs.irq_external = 1'b1;
  // interrupt waits for the stall to drop
  repeat (3) begin
    settle();
    check_eq("id ready in stall", 0, id_in_ready);
    check_eq("valid clear in stall", 0, valid_clear);
    check_eq("strobes in stall", 0, strobes);
    step();
  end
  stall_id = 1'b0;
  take_irq(cause_of(1'b1, 11));
  irqs   = '0;
  irq_en = 1'b0;
  settle();
  // halt released once the request is gone
  check_eq("id ready after stall", 1, id_in_ready);
endtask

//--- bench/ctrl_tb.sv
////////////////////////////////////////
// testbench top for the decode controller
// clock, reset, DUT, watchdog and test order
////////////////////////////////////////

module ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import ctrl_isa_pkg::*;
  import ctrl_pipe_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 5;
  // rough sum of the cycles the directed tests step through
  localparam int TEST_CYCLES   = 70;
  localparam int MARGIN_CYCLES = 40;

  logic       clk;
  logic       rst_n;
  instr_t     instr;
  dec_flags_t dec;
  irqs_t      irqs;
  logic       irq_nm;
  logic       irq_en;
  priv_lvl_e  priv_mode;
  logic       trap_wfi;
  logic       stall_id;
  pc_ctrl_t   pc_ctrl;
  logic       instr_req;
  logic       id_in_ready;
  logic       valid_clear;
  logic       flush_id;
  csr_ctrl_t  csr_ctrl;
  logic       nmi_mode;
  logic       ctrl_busy;
  // save_if, save_id, save_cause, restore_mret
  logic [3:0] strobes;

  string  test_name;
  integer seed = 32'h21ab73d3;

  assign strobes = {csr_ctrl.save_if, csr_ctrl.save_id, csr_ctrl.save_cause,
                    csr_ctrl.restore_mret};

  ctrl_top #(
    .NumFastIrq (15)
  ) ctrl_top_inst (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .instr_i             (instr),
    .dec_i               (dec),
    .irqs_i              (irqs),
    .irq_nm_i            (irq_nm),
    .irq_en_i            (irq_en),
    .priv_mode_i         (priv_mode),
    .trap_wfi_i          (trap_wfi),
    .stall_id_i          (stall_id),
    .pc_ctrl_o           (pc_ctrl),
    .instr_req_o         (instr_req),
    .id_in_ready_o       (id_in_ready),
    .instr_valid_clear_o (valid_clear),
    .flush_id_o          (flush_id),
    .csr_ctrl_o          (csr_ctrl),
    .nmi_mode_o          (nmi_mode),
    .ctrl_busy_o         (ctrl_busy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////

  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES));
    $display("timeout: the directed tests did not finish in time");
    $display("sim failed");
    $fatal(1);
  end

  task automatic check_eq(input string what, input logic [31:0] exp,
                          input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s: %s expected %0h actual %0h", test_name, what, exp, act);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  // wait for the next drive point at the falling edge
  task automatic step();
    @(negedge clk);
  endtask

  // let the combinational outputs follow the new inputs
  task automatic settle();
    #1;
  endtask

  // empty IF-ID register in M-mode with WFI trapping off
  task automatic clear_instr();
    instr     = '0;
    dec       = '0;
    priv_mode = PRIV_LVL_M;
    trap_wfi  = 1'b0;
  endtask

  task automatic check_redirect(input pc_sel_e sel);
    check_eq("pc set and select", {1'b1, sel}, {pc_ctrl.pc_set, pc_ctrl.pc_sel});
  endtask

  // expected cause word where the top bit marks an interrupt
  function automatic logic [5:0] cause_of(input logic irq, input int code);
    cause_of = {irq, code[4:0]};
  endfunction

  initial begin
    rst_n     = 1'b0;
    irqs      = '0;
    irq_nm    = 1'b0;
    irq_en    = 1'b0;
    stall_id  = 1'b0;
    test_name = "reset";
    clear_instr();
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    boot_sequence();
    illegal_and_fault();
    ecall_ebreak_mret();
    irq_priority();
    sleep_wakeup();
    branch_and_stall();
    $display("sim passed");
    $finish;
  end

  `include "ctrl_tests.svh"

endmodule

//--- vlog.f
+incdir+bench
hdl/ctrl_isa_pkg.sv
hdl/ctrl_pipe_pkg.sv
hdl/exc_detect.sv
hdl/irq_select.sv
hdl/ctrl_fsm.sv
hdl/ctrl_top.sv
bench/ctrl_tb.sv

//--- run.sh
#!/bin/sh
# build and run the decode controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module ctrl_tb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vctrl_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
